// ==== cmp_station_golden.txt ====
# Hex fields: R tag value ready | I op src1 src2 dest | B port tag value | E tag result
# F flush | W idle cycles | L expected full | D wait until all expected results are out
W 4
L 0
R 0 80000000 1
R 1 00000001 1
I 0 1 1 2
E 2 1
I 1 0 1 3
E 3 1
I 2 0 1 4
E 4 1
I 3 0 1 5
E 5 0
I 4 1 0 2
E 2 0
I 5 1 0 3
E 3 1
I 6 1 0 4
E 4 1
I 7 0 1 5
E 5 1
D
R 6 0000DEAD 0
I 3 1 6 7
E 7 0
B 0 6 00000001
R 6 00000001 1
D
R 3 00000000 0
I 1 0 1 3
E 3 1
I 0 3 1 4
E 4 1
D
R 5 00000000 0
R 6 00000000 0
I 2 5 6 2
E 2 1
I 3 5 6 3
E 3 0
I 5 6 5 4
E 4 1
I 0 5 6 7
E 7 0
L 1
B 0 5 FFFFFFFF
B 1 6 00000002
D
L 0
I 1 5 1 2
I 0 5 1 3
W 2
F
B 0 5 00000007
W 8
R 5 00000007 1
I 0 5 5 4
E 4 1

// ==== filelist.f ====
+incdir+.
rv32i_pkg.sv
tomasulo_pkg.sv
cmp_dispatch.sv
cmp_rs_slot.sv
cmp_cdb_drain.sv
cmp_station.sv
cmp_station_tb.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cmp_station_tb -f filelist.f -o cmp_station_sim

out=$(./obj_dir/cmp_station_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== cmp_station_tb.sv ====
`timescale 1ns/1ps
`include "cmp_config.svh"

module cmp_station_tb;
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int CYCLES_PER_RECORD = 20;
    localparam int DRAIN_LIMIT       = 64;

    logic                            clk;
    logic                            rst_n_i;
    logic                            flush_i;
    logic                            issue_valid_i;
    cmp_issue_t                      issue_i;
    word_t [`ROB_ENTRIES-1:0]        rob_value_i;
    logic [`ROB_ENTRIES-1:0]         rob_ready_i;
    cdb_entry_t [`EXT_CDB_PORTS-1:0] cdb_i;
    logic                            full_o;
    cdb_entry_t                      cdb_o;

    // One command letter and four hex fields per golden record
    byte          rec_cmd[$];
    logic [127:0] rec_arg[$];
    // Results still owed by the DUT, oldest first
    rob_tag_t     exp_tag[$];
    word_t        exp_val[$];
    int           errors = 0;
    int           checks = 0;
    int           watch_cycles = 0;

    cmp_station u_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .rob_value_i   (rob_value_i),
        .rob_ready_i   (rob_ready_i),
        .cdb_i         (cdb_i),
        .full_o        (full_o),
        .cdb_o         (cdb_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
                 watch_cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Each broadcast settles the oldest expectation with the same tag
    always @(negedge clk) begin
        int idx;
        idx = -1;
        if (rst_n_i && cdb_o.valid) begin
            for (int i = 0; i < exp_tag.size(); i++) begin
                if (idx < 0 && exp_tag[i] == cdb_o.tag) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                errors++;
                $display("Unexpected result on the CDB output for tag %0d", cdb_o.tag);
            end else begin
                check_value($sformatf("cdb_o.value tag %0d", cdb_o.tag), cdb_o.value,
                            exp_val[idx]);
                exp_tag.delete(idx);
                exp_val.delete(idx);
            end
        end
    end

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_tag.size() != 0 && n < DRAIN_LIMIT) begin
            next_cycle();
            n++;
        end
        foreach (exp_tag[i]) begin
            errors++;
            $display("Missing result for tag %0d", exp_tag[i]);
        end
        exp_tag.delete();
        exp_val.delete();
    endtask

    task automatic load_golden();
        int    fd;
        string line;
        byte   cmd;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        fd = $fopen("cmp_station_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the golden file cmp_station_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                cmd = 0;
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                if (line.len() > 1 && line[0] != "#") begin
                    void'($sscanf(line, "%c %h %h %h %h", cmd, a, b, c, d));
                    rec_cmd.push_back(cmd);
                    rec_arg.push_back({a, b, c, d});
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_record(input byte cmd, input logic [127:0] arg);
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        {a, b, c, d} = arg;
        case (cmd)
            "R": begin
                rob_value_i[a[2:0]] = b;
                rob_ready_i[a[2:0]] = c[0];
            end
            "I": begin
                // Decoder holds off while the cluster is full
                while (full_o) next_cycle();
                issue_valid_i = 1'b1;
                issue_i.op    = cmp_op_e'(a[2:0]);
                issue_i.src1  = b[2:0];
                issue_i.src2  = c[2:0];
                issue_i.dest  = d[2:0];
                next_cycle();
                issue_valid_i = 1'b0;
            end
            "B": begin
                cdb_i[a[0]] = '{valid: 1'b1, tag: b[2:0], value: c};
                next_cycle();
                cdb_i[a[0]].valid = 1'b0;
            end
            "F": begin
                flush_i = 1'b1;
                next_cycle();
                flush_i = 1'b0;
            end
            "W": repeat (a) next_cycle();
            "L": check_value("full_o", word_t'(full_o), a);
            "E": begin
                exp_tag.push_back(a[2:0]);
                exp_val.push_back(b);
            end
            "D": wait_drain();
            default: begin
                errors++;
                $display("Unknown golden record type '%c'", cmd);
            end
        endcase
    endtask

    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        rob_value_i   = '0;
        rob_ready_i   = '0;
        cdb_i         = '0;
        load_golden();
        watch_cycles = (rec_cmd.size() + 1) * CYCLES_PER_RECORD;
        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        foreach (rec_cmd[i]) begin
            run_record(rec_cmd[i], rec_arg[i]);
        end
        wait_drain();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cmp_station.sv ====
`timescale 1ns/1ps
`include "cmp_config.svh"

module cmp_station (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          flush_i,
    input  logic                                          issue_valid_i,
    input  tomasulo_pkg::cmp_issue_t                      issue_i,
    input  rv32i_pkg::word_t [`ROB_ENTRIES-1:0]           rob_value_i,
    input  logic [`ROB_ENTRIES-1:0]                       rob_ready_i,
    input  tomasulo_pkg::cdb_entry_t [`EXT_CDB_PORTS-1:0] cdb_i,
    output logic                                          full_o,
    output tomasulo_pkg::cdb_entry_t                      cdb_o
);
    import tomasulo_pkg::*;

    cdb_bus_t                             snoop;
    cmp_slot_load_t                       slot_load;
    logic [`CMP_RS_SLOTS-1:0]             slot_load_en;
    logic [`CMP_RS_SLOTS-1:0]             slot_busy;
    logic [`CMP_RS_SLOTS-1:0]             slot_done;
    logic [`CMP_RS_SLOTS-1:0]             grant;
    cdb_entry_t [`CMP_RS_SLOTS-1:0]       slot_result;

    // Own output feeds back as the top snoop port
    assign snoop = {cdb_o, cdb_i};

    cmp_dispatch u_dispatch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .rob_value_i    (rob_value_i),
        .rob_ready_i    (rob_ready_i),
        .snoop_i        (snoop),
        .slot_busy_i    (slot_busy),
        .slot_load_o    (slot_load),
        .slot_load_en_o (slot_load_en),
        .full_o         (full_o)
    );

    for (genvar i = 0; i < `CMP_RS_SLOTS; i++) begin : g_slot
        cmp_rs_slot u_slot (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .flush_i   (flush_i),
            .load_en_i (slot_load_en[i]),
            .load_i    (slot_load),
            .snoop_i   (snoop),
            .grant_i   (grant[i]),
            .busy_o    (slot_busy[i]),
            .done_o    (slot_done[i]),
            .result_o  (slot_result[i])
        );
    end

    cmp_cdb_drain u_drain (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .done_i    (slot_done),
        .results_i (slot_result),
        .grant_o   (grant),
        .cdb_o     (cdb_o)
    );

endmodule

// ==== cmp_cdb_drain.sv ====
`timescale 1ns/1ps
`include "cmp_config.svh"

module cmp_cdb_drain (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           flush_i,
    input  logic [`CMP_RS_SLOTS-1:0]                       done_i,
    input  tomasulo_pkg::cdb_entry_t [`CMP_RS_SLOTS-1:0]   results_i,
    output logic [`CMP_RS_SLOTS-1:0]                       grant_o,
    output tomasulo_pkg::cdb_entry_t                       cdb_o
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    cdb_entry_t granted;
    logic       out_valid_q;
    rob_tag_t   out_tag_q;
    word_t      out_value_q;

    // Fixed priority, lowest index wins
    assign grant_o = done_i & (~done_i + 1'b1);

    always_comb begin
        granted = '0;
        for (int i = 0; i < `CMP_RS_SLOTS; i++) begin
            if (grant_o[i]) begin
                granted = results_i[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= |grant_o;
        end
    end

    always_ff @(posedge clk) begin
        out_tag_q   <= granted.tag;
        out_value_q <= granted.value;
    end

    assign cdb_o = '{valid: out_valid_q, tag: out_tag_q, value: out_value_q};

    // A granted slot must present a valid result entry
    a_grant_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            (|grant_o) |-> granted.valid
    ) else $error("cmp_cdb_drain: grant of an invalid result");

endmodule

// ==== cmp_rs_slot.sv ====
`timescale 1ns/1ps
`include "cmp_config.svh"

module cmp_rs_slot (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         load_en_i,
    input  tomasulo_pkg::cmp_slot_load_t load_i,
    input  tomasulo_pkg::cdb_bus_t       snoop_i,
    input  logic                         grant_i,
    output logic                         busy_o,
    output logic                         done_o,
    output tomasulo_pkg::cdb_entry_t     result_o
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    typedef enum logic [1:0] {
        SLOT_FREE,
        SLOT_WAIT,
        SLOT_DONE
    } slot_state_e;

    slot_state_e state_q;
    cmp_op_e     op_q;
    operand_t    src1_q;
    operand_t    src2_q;
    operand_t    src1_d;
    operand_t    src2_d;
    rob_tag_t    dest_q;
    logic        result_q;
    logic        operands_ready;

    function automatic logic compare(cmp_op_e op, word_t a, word_t b);
        logic r;
        case (op)
            CMP_BEQ:  r = (a == b);
            CMP_BNE:  r = (a != b);
            CMP_SLT:  r = ($signed(a) < $signed(b));
            CMP_BLT:  r = ($signed(a) < $signed(b));
            CMP_BGE:  r = ($signed(a) >= $signed(b));
            CMP_SLTU: r = (a < b);
            CMP_BLTU: r = (a < b);
            CMP_BGEU: r = (a >= b);
        endcase
        return r;
    endfunction

    // Snoop also applies on the load edge, a broadcast there is not lost
    always_comb begin
        src1_d = snoop_operand(load_en_i ? load_i.src1 : src1_q, snoop_i);
        src2_d = snoop_operand(load_en_i ? load_i.src2 : src2_q, snoop_i);
    end

    assign operands_ready = src1_q.ready && src2_q.ready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= SLOT_FREE;
        end else if (flush_i) begin
            state_q <= SLOT_FREE;
        end else begin
            case (state_q)
                SLOT_FREE: if (load_en_i) state_q <= SLOT_WAIT;
                SLOT_WAIT: if (operands_ready) state_q <= SLOT_DONE;
                SLOT_DONE: if (grant_i) state_q <= SLOT_FREE;
                default:   state_q <= SLOT_FREE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            op_q   <= load_i.op;
            dest_q <= load_i.dest;
        end
        if (load_en_i || state_q == SLOT_WAIT) begin
            src1_q <= src1_d;
            src2_q <= src2_d;
        end
        // Result held until the drain takes it
        if (state_q == SLOT_WAIT && operands_ready) begin
            result_q <= compare(op_q, src1_q.value, src2_q.value);
        end
    end

    assign busy_o         = (state_q != SLOT_FREE);
    assign done_o         = (state_q == SLOT_DONE);
    assign result_o.valid = done_o;
    assign result_o.tag   = dest_q;
    assign result_o.value = word_t'(result_q);

    a_load_only_free: assert property (
        @(posedge clk) disable iff (!rst_n_i) load_en_i |-> state_q == SLOT_FREE
    ) else $error("cmp_rs_slot: load into occupied slot");

    a_grant_only_done: assert property (
        @(posedge clk) disable iff (!rst_n_i) grant_i |-> state_q == SLOT_DONE
    ) else $error("cmp_rs_slot: grant without result");

endmodule

// ==== cmp_dispatch.sv ====
`timescale 1ns/1ps
`include "cmp_config.svh"

module cmp_dispatch (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                issue_valid_i,
    input  tomasulo_pkg::cmp_issue_t            issue_i,
    input  rv32i_pkg::word_t [`ROB_ENTRIES-1:0] rob_value_i,
    input  logic [`ROB_ENTRIES-1:0]             rob_ready_i,
    input  tomasulo_pkg::cdb_bus_t              snoop_i,
    input  logic [`CMP_RS_SLOTS-1:0]            slot_busy_i,
    output tomasulo_pkg::cmp_slot_load_t        slot_load_o,
    output logic [`CMP_RS_SLOTS-1:0]            slot_load_en_o,
    output logic                                full_o
);
    import tomasulo_pkg::*;

    operand_t                 rob_src1;
    operand_t                 rob_src2;
    operand_t                 src1_res;
    operand_t                 src2_res;
    logic [`CMP_RS_SLOTS-1:0] avail;
    logic [`CMP_RS_SLOTS-1:0] pick;
    logic [`CMP_RS_SLOTS-1:0] pick_en;

    // ROB view of each source, ready bit folded in after the snoop
    assign rob_src1 = '{ready: 1'b0, tag: issue_i.src1, value: rob_value_i[issue_i.src1]};
    assign rob_src2 = '{ready: 1'b0, tag: issue_i.src2, value: rob_value_i[issue_i.src2]};

    // A same-cycle broadcast overrides the ROB value
    always_comb begin
        src1_res = snoop_operand(rob_src1, snoop_i);
        src2_res = snoop_operand(rob_src2, snoop_i);
        src1_res.ready = src1_res.ready | rob_ready_i[issue_i.src1];
        src2_res.ready = src2_res.ready | rob_ready_i[issue_i.src2];
    end

    // Slot with a load in flight is not yet busy, so mask it out
    assign avail   = ~slot_busy_i & ~slot_load_en_o;
    // Lowest set bit
    assign pick    = avail & (~avail + 1'b1);
    assign pick_en = issue_valid_i ? pick : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_load_en_o <= '0;
            full_o         <= 1'b0;
        end else if (flush_i) begin
            slot_load_en_o <= '0;
            full_o         <= 1'b0;
        end else begin
            slot_load_en_o <= pick_en;
            full_o         <= &(slot_busy_i | slot_load_en_o | pick_en);
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            slot_load_o <= '{op: issue_i.op, src1: src1_res, src2: src2_res,
                             dest: issue_i.dest};
        end
    end

    // Decoder has no back-pressure and must respect full
    a_no_issue_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i) issue_valid_i |-> !full_o
    ) else $error("cmp_dispatch: issue while full");

endmodule

// ==== tomasulo_pkg.sv ====
`include "cmp_config.svh"

package tomasulo_pkg;

    localparam int SNOOP_PORTS = `EXT_CDB_PORTS + 1;

    typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_tag_t;

    // Source operand, value is only meaningful once ready is set
    typedef struct packed {
        logic             ready;
        rob_tag_t         tag;
        rv32i_pkg::word_t value;
    } operand_t;

    // Micro-op from the decoder
    typedef struct packed {
        rv32i_pkg::cmp_op_e op;
        rob_tag_t           src1;
        rob_tag_t           src2;
        rob_tag_t           dest;
    } cmp_issue_t;

    // Resolved micro-op written into a slot
    typedef struct packed {
        rv32i_pkg::cmp_op_e op;
        operand_t           src1;
        operand_t           src2;
        rob_tag_t           dest;
    } cmp_slot_load_t;

    typedef struct packed {
        logic             valid;
        rob_tag_t         tag;
        rv32i_pkg::word_t value;
    } cdb_entry_t;

    // External ports low, own output in the top element
    typedef cdb_entry_t [SNOOP_PORTS-1:0] cdb_bus_t;

    // Capture a broadcast for an operand that is still waiting
    function automatic operand_t snoop_operand(operand_t opnd, cdb_bus_t bus);
        operand_t res;
        res = opnd;
        for (int j = 0; j < SNOOP_PORTS; j++) begin
            if (!opnd.ready && bus[j].valid && bus[j].tag == opnd.tag) begin
                res.ready = 1'b1;
                res.value = bus[j].value;
            end
        end
        return res;
    endfunction

endpackage

// ==== rv32i_pkg.sv ====
`include "cmp_config.svh"

package rv32i_pkg;

    // Architectural data word
    typedef logic [`XLEN-1:0] word_t;

    // Compare operations
    // Branch ops follow the branch funct3 encoding
    // slt and sltu fill the two unused branch codes
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_SLT  = 3'b010,
        CMP_SLTU = 3'b011,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_e;

endpackage

// ==== cmp_config.svh ====
`ifndef CMP_CONFIG_SVH
`define CMP_CONFIG_SVH

// Sizing of the compare cluster

// Reservation slots in the cluster
`define CMP_RS_SLOTS 4

// ROB depth, sets the tag width
`define ROB_ENTRIES 8

// Broadcast ports from the other functional units
//   the cluster's own output is added on top of these
`define EXT_CDB_PORTS 2

// Data word width
`define XLEN 32

`endif
